// File: include/mem_cluster_assert.svh
/*
 * Assertion helper macros for the memory cluster RTL:
 * elaboration-time checks and clocked properties on clk_i / rst_ni
 */
`ifndef MEM_CLUSTER_ASSERT_SVH
`define MEM_CLUSTER_ASSERT_SVH

// Elaboration check, fails the build when cond is false
`define CLUSTER_STATIC_ASSERT(cond, msg) \
    if (!(cond)) begin \
        $error(msg); \
    end

// Concurrent property, idle while reset is asserted
`define CLUSTER_ASSERT(name, prop, msg) \
    name: assert property (@(posedge clk_i) disable iff (!rst_ni) (prop)) \
        else $error(msg);

`endif

// File: source/mem_cluster_pkg.sv
/*
 * Memory cluster package: bank counts and widths, vector typedefs,
 * narrow/wide port structs and bank-side request/select structs
 */
`default_nettype none

package mem_cluster_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int unsigned NumNarrowBanks  = 4;
    localparam int unsigned NumWideBanks    = 2;
    localparam int unsigned NarrowPerWide   = 2;
    localparam int unsigned BankWords       = 64;

    localparam int unsigned NarrowDataWidth = 32;
    localparam int unsigned WideDataWidth   = 64;
    localparam int unsigned BankAddrWidth   = $clog2(BankWords);

    // --------------------
    // Vector types
    // --------------------
    typedef logic [NarrowDataWidth-1:0]   narrow_data_t;
    typedef logic [NarrowDataWidth/8-1:0] narrow_strb_t;
    // Low half belongs to the even bank of a pair
    typedef logic [WideDataWidth-1:0]     wide_data_t;
    typedef logic [WideDataWidth/8-1:0]   wide_strb_t;
    typedef logic [BankAddrWidth-1:0]     bank_addr_t;

    // --------------------
    // Port structs
    // --------------------
    typedef struct packed {
        bank_addr_t   addr;
        logic         write;
        narrow_data_t data;
        narrow_strb_t strb;
    } narrow_q_t;

    typedef struct packed {
        bank_addr_t addr;
        logic       write;
        wide_data_t data;
        wide_strb_t strb;
    } wide_q_t;

    typedef struct packed {
        logic      valid;
        narrow_q_t q;
    } narrow_req_t;

    typedef struct packed {
        logic         q_ready;
        logic         p_valid;
        narrow_data_t p_data;
    } narrow_rsp_t;

    typedef struct packed {
        logic    valid;
        wide_q_t q;
    } wide_req_t;

    typedef struct packed {
        logic       q_ready;
        logic       p_valid;
        wide_data_t p_data;
    } wide_rsp_t;

    // Arbiter decision for one bank
    typedef struct packed {
        logic en;
        logic from_wide;
    } bank_sel_t;

    typedef struct packed {
        logic         en;
        logic         write;
        bank_addr_t   addr;
        narrow_data_t data;
        narrow_strb_t strb;
    } bank_req_t;

endpackage

`default_nettype wire

// File: source/wide_narrow_arbiter.sv
/*
 * Alternating-priority arbiter between the narrow and wide ports,
 * producing q_ready vectors and the per-bank selection
 */
`timescale 1ns/100ps
`default_nettype none

`include "mem_cluster_assert.svh"

module wide_narrow_arbiter (
    input  logic clk_i,
    input  logic rst_ni,

    input  mem_cluster_pkg::narrow_req_t [mem_cluster_pkg::NumNarrowBanks-1:0] narrow_req_i,
    input  mem_cluster_pkg::wide_req_t   [mem_cluster_pkg::NumWideBanks-1:0]   wide_req_i,

    output logic [mem_cluster_pkg::NumNarrowBanks-1:0] narrow_ready_o,
    output logic [mem_cluster_pkg::NumWideBanks-1:0]   wide_ready_o,

    output mem_cluster_pkg::bank_sel_t [mem_cluster_pkg::NumNarrowBanks-1:0] bank_sel_o
);

    import mem_cluster_pkg::*;

    logic                      narrow_first_q;
    logic [NumNarrowBanks-1:0] wide_valid_split;
    logic [NumWideBanks-1:0]   narrow_valid_merged;
    logic [NumNarrowBanks-1:0] narrow_gnt;
    logic [NumWideBanks-1:0]   wide_gnt;
    logic [NumNarrowBanks-1:0] wide_gnt_split;

    // Priority flips every cycle, narrow side first out of reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            narrow_first_q <= 1'b1;
        end else begin
            narrow_first_q <= ~narrow_first_q;
        end
    end

    // --------------------
    // Valid reshaping
    // --------------------
    always_comb begin
        for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
            wide_valid_split[i] = wide_req_i[i / NarrowPerWide].valid;
        end
    end

    // A pair counts as busy when any of its narrow ports is valid
    always_comb begin
        for (int unsigned j = 0; j < NumWideBanks; j++) begin
            narrow_valid_merged[j] = 1'b0;
            for (int unsigned k = 0; k < NarrowPerWide; k++) begin
                narrow_valid_merged[j] |= narrow_req_i[j * NarrowPerWide + k].valid;
            end
        end
    end

    // --------------------
    // Grants
    // --------------------
    always_comb begin
        for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
            narrow_ready_o[i] = narrow_first_q | ~wide_valid_split[i];
            narrow_gnt[i]     = narrow_req_i[i].valid & narrow_ready_o[i];
        end
        for (int unsigned j = 0; j < NumWideBanks; j++) begin
            wide_ready_o[j] = ~narrow_first_q | ~narrow_valid_merged[j];
            wide_gnt[j]     = wide_req_i[j].valid & wide_ready_o[j];
        end
    end

    // Wide grant fans out to every bank of its pair
    always_comb begin
        for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
            wide_gnt_split[i]       = wide_gnt[i / NarrowPerWide];
            bank_sel_o[i].en        = narrow_gnt[i] | wide_gnt_split[i];
            bank_sel_o[i].from_wide = wide_gnt_split[i];
        end
    end

    // --------------------
    // Assertions
    // --------------------
    `CLUSTER_STATIC_ASSERT(NarrowPerWide * $bits(narrow_data_t) == $bits(wide_data_t),
        "Wide word must span exactly NarrowPerWide narrow words")

    for (genvar b = 0; b < NumNarrowBanks; b++) begin : g_bank_chk
        `CLUSTER_ASSERT(excl_gnt_a, !(narrow_gnt[b] && wide_gnt_split[b]),
            "Bank granted to narrow and wide side in the same cycle")
    end

    for (genvar j = 0; j < NumWideBanks; j++) begin : g_pair_chk
        // First and last bank of the span must both be taken by the wide side
        `CLUSTER_ASSERT(pair_en_a,
            wide_gnt[j] |-> (bank_sel_o[j * NarrowPerWide].en
                && bank_sel_o[j * NarrowPerWide + NarrowPerWide - 1].en
                && bank_sel_o[j * NarrowPerWide].from_wide
                && bank_sel_o[j * NarrowPerWide + NarrowPerWide - 1].from_wide),
            "Wide grant did not enable both banks of its pair")
    end

endmodule

`default_nettype wire

// File: source/bank_port_mux.sv
/*
 * Per-bank port mux: selects the granted narrow or wide source
 * and steers the bank read data back to its owner one cycle later
 */
`timescale 1ns/100ps
`default_nettype none

`include "mem_cluster_assert.svh"

module bank_port_mux (
    input  logic clk_i,
    input  logic rst_ni,

    // Decision from the arbiter
    input  mem_cluster_pkg::bank_sel_t    sel_i,

    // Narrow source for this bank
    input  mem_cluster_pkg::narrow_q_t    narrow_q_i,

    // Wide source, already cut down to this bank's slice
    input  mem_cluster_pkg::narrow_data_t wide_data_i,
    input  mem_cluster_pkg::narrow_strb_t wide_strb_i,
    input  mem_cluster_pkg::bank_addr_t   wide_addr_i,
    input  logic                          wide_write_i,

    // Bank side
    output mem_cluster_pkg::bank_req_t    bank_req_o,
    input  mem_cluster_pkg::narrow_data_t bank_rdata_i,

    // Response side
    output logic                          narrow_p_valid_o,
    output logic                          wide_p_valid_o,
    output mem_cluster_pkg::narrow_data_t p_data_o
);

    import mem_cluster_pkg::*;

    logic en_q;
    logic from_wide_q;

    // --------------------
    // Request selection
    // --------------------
    always_comb begin
        bank_req_o.en = sel_i.en;
        if (sel_i.from_wide) begin
            bank_req_o.write = wide_write_i;
            bank_req_o.addr  = wide_addr_i;
            bank_req_o.data  = wide_data_i;
            bank_req_o.strb  = wide_strb_i;
        end else begin
            bank_req_o.write = narrow_q_i.write;
            bank_req_o.addr  = narrow_q_i.addr;
            bank_req_o.data  = narrow_q_i.data;
            bank_req_o.strb  = narrow_q_i.strb;
        end
    end

    // --------------------
    // Owner of the access in flight
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            en_q        <= 1'b0;
            from_wide_q <= 1'b0;
        end else begin
            en_q        <= sel_i.en;
            from_wide_q <= sel_i.from_wide;
        end
    end

    // Read data goes to whichever side issued last cycle's access
    assign narrow_p_valid_o = en_q & ~from_wide_q;
    assign wide_p_valid_o   = en_q & from_wide_q;
    assign p_data_o         = bank_rdata_i;

    // --------------------
    // Assertions
    // --------------------
    `CLUSTER_ASSERT(p_valid_excl_a, !(narrow_p_valid_o && wide_p_valid_o),
        "Narrow and wide response on the same bank in one cycle")

endmodule

`default_nettype wire

// File: source/mem_bank.sv
/*
 * Single SRAM bank, one-cycle read latency, byte strobes,
 * read-before-write so a write returns the old word
 */
`timescale 1ns/100ps
`default_nettype none

module mem_bank (
    input  logic                          clk_i,
    input  logic                          rst_ni,

    input  mem_cluster_pkg::bank_req_t    req_i,
    output mem_cluster_pkg::narrow_data_t rdata_o
);

    import mem_cluster_pkg::*;

    localparam int unsigned NumBytes = $bits(narrow_strb_t);

    narrow_data_t mem_q [BankWords];

    // --------------------
    // Read port
    // --------------------
    // Old content is captured on every access, writes included
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_o <= '0;
        end else if (req_i.en) begin
            rdata_o <= mem_q[req_i.addr];
        end
    end

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk_i) begin
        if (req_i.en && req_i.write) begin
            for (int unsigned b = 0; b < NumBytes; b++) begin
                if (req_i.strb[b]) begin
                    mem_q[req_i.addr][b*8 +: 8] <= req_i.data[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/mem_cluster_top.sv
/*
 * Memory cluster top: arbiter, per-bank muxes and banks,
 * wide data split and read data merge
 */
`timescale 1ns/100ps
`default_nettype none

`include "mem_cluster_assert.svh"

module mem_cluster_top (
    input  logic clk_i,
    input  logic rst_ni,

    input  mem_cluster_pkg::narrow_req_t [mem_cluster_pkg::NumNarrowBanks-1:0] narrow_req_i,
    output mem_cluster_pkg::narrow_rsp_t [mem_cluster_pkg::NumNarrowBanks-1:0] narrow_rsp_o,

    input  mem_cluster_pkg::wide_req_t   [mem_cluster_pkg::NumWideBanks-1:0]   wide_req_i,
    output mem_cluster_pkg::wide_rsp_t   [mem_cluster_pkg::NumWideBanks-1:0]   wide_rsp_o
);

    import mem_cluster_pkg::*;

    logic [NumNarrowBanks-1:0]       narrow_ready;
    logic [NumWideBanks-1:0]         wide_ready;
    bank_sel_t    [NumNarrowBanks-1:0] bank_sel;
    bank_req_t    [NumNarrowBanks-1:0] bank_req;
    narrow_data_t [NumNarrowBanks-1:0] bank_rdata;
    narrow_data_t [NumNarrowBanks-1:0] bank_p_data;
    logic [NumNarrowBanks-1:0]       narrow_p_valid;
    logic [NumNarrowBanks-1:0]       wide_p_valid;

    wide_narrow_arbiter u_arbiter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .narrow_req_i   (narrow_req_i),
        .wide_req_i     (wide_req_i),
        .narrow_ready_o (narrow_ready),
        .wide_ready_o   (wide_ready),
        .bank_sel_o     (bank_sel)
    );

    // --------------------
    // Banks
    // --------------------
    for (genvar i = 0; i < NumNarrowBanks; i++) begin : g_bank
        // Pair index and slice within the wide word
        localparam int unsigned Pair = i / NarrowPerWide;
        localparam int unsigned Half = i % NarrowPerWide;

        bank_port_mux u_mux (
            .clk_i            (clk_i),
            .rst_ni           (rst_ni),
            .sel_i            (bank_sel[i]),
            .narrow_q_i       (narrow_req_i[i].q),
            .wide_data_i      (wide_req_i[Pair].q.data[Half*NarrowDataWidth +: NarrowDataWidth]),
            .wide_strb_i      (wide_req_i[Pair].q.strb[Half*NarrowDataWidth/8 +: NarrowDataWidth/8]),
            .wide_addr_i      (wide_req_i[Pair].q.addr),
            .wide_write_i     (wide_req_i[Pair].q.write),
            .bank_req_o       (bank_req[i]),
            .bank_rdata_i     (bank_rdata[i]),
            .narrow_p_valid_o (narrow_p_valid[i]),
            .wide_p_valid_o   (wide_p_valid[i]),
            .p_data_o         (bank_p_data[i])
        );

        mem_bank u_bank (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .req_i   (bank_req[i]),
            .rdata_o (bank_rdata[i])
        );

        assign narrow_rsp_o[i].q_ready = narrow_ready[i];
        assign narrow_rsp_o[i].p_valid = narrow_p_valid[i];
        assign narrow_rsp_o[i].p_data  = bank_p_data[i];
    end

    // --------------------
    // Wide responses
    // --------------------
    for (genvar j = 0; j < NumWideBanks; j++) begin : g_wide
        assign wide_rsp_o[j].q_ready = wide_ready[j];
        // Even bank carries the valid, odd bank the upper word
        assign wide_rsp_o[j].p_valid = wide_p_valid[j*NarrowPerWide];
        assign wide_rsp_o[j].p_data  = {bank_p_data[j*NarrowPerWide + 1],
                                        bank_p_data[j*NarrowPerWide]};

        `CLUSTER_ASSERT(pair_rsp_a,
            wide_p_valid[j*NarrowPerWide] == wide_p_valid[j*NarrowPerWide + 1],
            "Banks of a wide pair responded in different cycles")
    end

endmodule

`default_nettype wire

// File: tests/tb_mem_cluster.sv
/*
 * Testbench for the memory cluster: stimulus table, reference memory
 * and priority mirror, per-cycle ready and response checks
 */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_cluster;

    import mem_cluster_pkg::*;

    localparam int IssueTimeout = 8;
    localparam int PhaseTimeout = 4;

    typedef struct {
        string                          name;
        bit                             wide_first;
        bit                             hold;
        logic [NumNarrowBanks-1:0]      nv;
        logic [NumWideBanks-1:0]        wv;
        narrow_q_t [NumNarrowBanks-1:0] nq;
        wide_q_t   [NumWideBanks-1:0]   wq;
    } entry_t;

    logic clk_i;
    logic rst_ni;

    narrow_req_t [NumNarrowBanks-1:0] narrow_req;
    narrow_rsp_t [NumNarrowBanks-1:0] narrow_rsp;
    wide_req_t   [NumWideBanks-1:0]   wide_req;
    wide_rsp_t   [NumWideBanks-1:0]   wide_rsp;

    // Reference model state
    narrow_data_t              ref_mem [NumNarrowBanks][BankWords];
    logic                      nf_mirror;
    logic [NumNarrowBanks-1:0] exp_nv;
    logic [NumWideBanks-1:0]   exp_wv;
    narrow_data_t              exp_nd [NumNarrowBanks];
    wide_data_t                exp_wd [NumWideBanks];

    logic [NumNarrowBanks-1:0] todo_n;
    logic [NumWideBanks-1:0]   todo_w;
    entry_t                    cur;
    entry_t                    stim_q [$];
    int                        test_errors;
    int                        errors;
    int                        n_tests;
    int                        n_failed;

    mem_cluster_top u_dut (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .narrow_req_i (narrow_req),
        .narrow_rsp_o (narrow_rsp),
        .wide_req_i   (wide_req),
        .wide_rsp_o   (wide_rsp)
    );

    always #5 clk_i = ~clk_i;

    // --------------------
    // Helpers
    // --------------------
    function automatic narrow_q_t narrow_op(bank_addr_t addr, logic write, narrow_data_t data,
                                            narrow_strb_t strb);
        narrow_q_t q;
        q.addr  = addr;
        q.write = write;
        q.data  = data;
        q.strb  = strb;
        return q;
    endfunction

    function automatic wide_q_t wide_op(bank_addr_t addr, logic write, wide_data_t data,
                                        wide_strb_t strb);
        wide_q_t q;
        q.addr  = addr;
        q.write = write;
        q.data  = data;
        q.strb  = strb;
        return q;
    endfunction

    function automatic entry_t blank_entry(string name, bit wide_first, bit hold);
        entry_t e;
        e.name       = name;
        e.wide_first = wide_first;
        e.hold       = hold;
        e.nv         = '0;
        e.wv         = '0;
        e.nq         = '0;
        e.wq         = '0;
        return e;
    endfunction

    // Byte lanes with strobe set take the new data
    function automatic narrow_data_t merge_bytes(narrow_data_t old, narrow_data_t data,
                                                 narrow_strb_t strb);
        narrow_data_t r;
        r = old;
        for (int k = 0; k < $bits(narrow_strb_t); k++) begin
            if (strb[k]) begin
                r[k*8 +: 8] = data[k*8 +: 8];
            end
        end
        return r;
    endfunction

    task automatic compare_value(string what, logic [63:0] exp, logic [63:0] act);
        assert (act === exp) else begin
            $display("FAILED %s %s expected %h actual %h", cur.name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_responses();
        for (int i = 0; i < NumNarrowBanks; i++) begin
            compare_value($sformatf("narrow%0d p_valid", i), exp_nv[i], narrow_rsp[i].p_valid);
            if (exp_nv[i]) begin
                compare_value($sformatf("narrow%0d p_data", i), exp_nd[i], narrow_rsp[i].p_data);
            end
        end
        for (int j = 0; j < NumWideBanks; j++) begin
            compare_value($sformatf("wide%0d p_valid", j), exp_wv[j], wide_rsp[j].p_valid);
            if (exp_wv[j]) begin
                compare_value($sformatf("wide%0d p_data", j), exp_wd[j], wide_rsp[j].p_data);
            end
        end
    endtask

    // Old word is the response, then the write lands in the reference
    task automatic predict(logic [NumNarrowBanks-1:0] acc_n, logic [NumWideBanks-1:0] acc_w);
        bank_addr_t  a;
        int unsigned b;
        exp_nv = acc_n;
        exp_wv = acc_w;
        for (int i = 0; i < NumNarrowBanks; i++) begin
            if (acc_n[i]) begin
                a         = cur.nq[i].addr;
                exp_nd[i] = ref_mem[i][a];
                if (cur.nq[i].write) begin
                    ref_mem[i][a] = merge_bytes(ref_mem[i][a], cur.nq[i].data, cur.nq[i].strb);
                end
            end
        end
        for (int j = 0; j < NumWideBanks; j++) begin
            if (acc_w[j]) begin
                a         = cur.wq[j].addr;
                b         = j * NarrowPerWide;
                exp_wd[j] = {ref_mem[b+1][a], ref_mem[b][a]};
                if (cur.wq[j].write) begin
                    ref_mem[b][a]   = merge_bytes(ref_mem[b][a], cur.wq[j].data[31:0],
                                                  cur.wq[j].strb[3:0]);
                    ref_mem[b+1][a] = merge_bytes(ref_mem[b+1][a], cur.wq[j].data[63:32],
                                                  cur.wq[j].strb[7:4]);
                end
            end
        end
    endtask

    // One clock cycle, entered and left on a falling edge
    task automatic run_cycle();
        logic [NumNarrowBanks-1:0] rdy_n;
        logic [NumWideBanks-1:0]   rdy_w;
        logic [NumNarrowBanks-1:0] got_n;
        logic [NumWideBanks-1:0]   got_w;
        for (int i = 0; i < NumNarrowBanks; i++) begin
            narrow_req[i].valid = todo_n[i];
            narrow_req[i].q     = cur.nq[i];
        end
        for (int j = 0; j < NumWideBanks; j++) begin
            wide_req[j].valid = todo_w[j];
            wide_req[j].q     = cur.wq[j];
        end
        #1;
        // Grant rule with the mirrored priority bit
        for (int i = 0; i < NumNarrowBanks; i++) begin
            rdy_n[i] = nf_mirror | ~todo_w[i / NarrowPerWide];
            got_n[i] = narrow_rsp[i].q_ready;
            compare_value($sformatf("narrow%0d q_ready", i), rdy_n[i], narrow_rsp[i].q_ready);
        end
        for (int j = 0; j < NumWideBanks; j++) begin
            rdy_w[j] = ~nf_mirror | ~(todo_n[2*j] | todo_n[2*j+1]);
            got_w[j] = wide_rsp[j].q_ready;
            compare_value($sformatf("wide%0d q_ready", j), rdy_w[j], wide_rsp[j].q_ready);
        end
        predict(todo_n & rdy_n, todo_w & rdy_w);
        // A request retires once the DUT raises q_ready for it
        todo_n = todo_n & ~got_n;
        todo_w = todo_w & ~got_w;
        @(posedge clk_i);
        nf_mirror = ~nf_mirror;
        @(negedge clk_i);
        check_responses();
    endtask

    task automatic run_entry(entry_t e);
        int waited;
        int issued;
        bit stalled;
        cur         = e;
        test_errors = 0;
        todo_n      = '0;
        todo_w      = '0;
        waited      = 0;
        while (nf_mirror == e.wide_first && waited < PhaseTimeout) begin
            run_cycle();
            waited++;
        end
        assert (nf_mirror != e.wide_first) else begin
            $display("%s: timeout while waiting for the priority phase", e.name);
            test_errors++;
        end
        todo_n  = e.nv;
        todo_w  = e.wv;
        issued  = 0;
        stalled = 1'b0;
        while ((todo_n != '0 || todo_w != '0) && issued < IssueTimeout) begin
            run_cycle();
            issued++;
            if (issued == 1) begin
                stalled = (todo_n != '0 || todo_w != '0);
            end
        end
        assert (todo_n == '0 && todo_w == '0) else begin
            $display("%s: timeout, requests were never accepted", e.name);
            test_errors++;
        end
        compare_value("stall in first cycle", e.hold, stalled);
        assert (issued <= 2) else begin
            $display("%s: held request was not served on the following cycle", e.name);
            test_errors++;
        end
        n_tests++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("pass  %s", e.name);
        end else begin
            n_failed++;
            $display("fail  %s (%0d errors)", e.name, test_errors);
        end
    endtask

    // --------------------
    // Stimulus table
    // --------------------
    task automatic build_table();
        entry_t e;
        e = blank_entry("reset_all_valid", 1'b0, 1'b1);
        e.nv = '1;
        e.wv = '1;
        for (int i = 0; i < NumNarrowBanks; i++) e.nq[i] = narrow_op(1, 1'b1, $urandom(), 4'hf);
        for (int j = 0; j < NumWideBanks; j++) begin
            e.wq[j] = wide_op(2, 1'b1, {$urandom(), $urandom()}, 8'hff);
        end
        stim_q.push_back(e);
        e = blank_entry("narrow_write", 1'b1, 1'b0);
        e.nv = '1;
        for (int i = 0; i < NumNarrowBanks; i++) e.nq[i] = narrow_op(5, 1'b1, $urandom(), 4'hf);
        stim_q.push_back(e);
        e.name = "narrow_overwrite";
        e.wide_first = 1'b0;
        for (int i = 0; i < NumNarrowBanks; i++) e.nq[i] = narrow_op(5, 1'b1, $urandom(), 4'hf);
        stim_q.push_back(e);
        e.name = "narrow_read";
        for (int i = 0; i < NumNarrowBanks; i++) e.nq[i] = narrow_op(5, 1'b0, '0, '0);
        stim_q.push_back(e);
        e = blank_entry("wide_write", 1'b1, 1'b0);
        e.wv = '1;
        for (int j = 0; j < NumWideBanks; j++) begin
            e.wq[j] = wide_op(10, 1'b1, {$urandom(), $urandom()}, 8'hff);
        end
        stim_q.push_back(e);
        e = blank_entry("narrow_read_halves", 1'b0, 1'b0);
        e.nv = '1;
        for (int i = 0; i < NumNarrowBanks; i++) e.nq[i] = narrow_op(10, 1'b0, '0, '0);
        stim_q.push_back(e);
        e.name = "narrow_write_pair";
        for (int i = 0; i < NumNarrowBanks; i++) e.nq[i] = narrow_op(12, 1'b1, $urandom(), 4'hf);
        stim_q.push_back(e);
        e = blank_entry("wide_read_concat", 1'b1, 1'b0);
        e.wv = '1;
        for (int j = 0; j < NumWideBanks; j++) e.wq[j] = wide_op(12, 1'b0, '0, '0);
        stim_q.push_back(e);
        // Wide side wins its pair, the other pair goes through
        e = blank_entry("conflict_wide_first", 1'b1, 1'b1);
        e.nv = '1;
        e.wv = 2'b01;
        for (int i = 0; i < NumNarrowBanks; i++) e.nq[i] = narrow_op(1, 1'b0, '0, '0);
        e.wq[0] = wide_op(2, 1'b0, '0, '0);
        stim_q.push_back(e);
        e = blank_entry("conflict_narrow_first", 1'b0, 1'b1);
        e.nv = 4'b0010;
        e.wv = 2'b11;
        e.nq[1] = narrow_op(10, 1'b0, '0, '0);
        for (int j = 0; j < NumWideBanks; j++) e.wq[j] = wide_op(12, 1'b0, '0, '0);
        stim_q.push_back(e);
        e = blank_entry("disjoint_pairs", 1'b0, 1'b0);
        e.nv = 4'b1100;
        e.wv = 2'b01;
        for (int i = 2; i < NumNarrowBanks; i++) e.nq[i] = narrow_op(5, 1'b0, '0, '0);
        e.wq[0] = wide_op(10, 1'b0, '0, '0);
        stim_q.push_back(e);
        // Partial strobes on both sides
        e = blank_entry("strobe_narrow", 1'b0, 1'b0);
        e.nv = '1;
        e.nq[0] = narrow_op(10, 1'b1, $urandom(), 4'b0101);
        e.nq[1] = narrow_op(10, 1'b1, $urandom(), 4'b1010);
        e.nq[2] = narrow_op(10, 1'b1, $urandom(), 4'b0011);
        e.nq[3] = narrow_op(10, 1'b1, $urandom(), 4'b1100);
        stim_q.push_back(e);
        e = blank_entry("strobe_wide", 1'b1, 1'b0);
        e.wv = '1;
        e.wq[0] = wide_op(5, 1'b1, {$urandom(), $urandom()}, 8'b1001_0110);
        e.wq[1] = wide_op(5, 1'b1, {$urandom(), $urandom()}, 8'b0111_0001);
        stim_q.push_back(e);
        e = blank_entry("strobe_readback", 1'b1, 1'b1);
        e.nv = '1;
        e.wv = '1;
        for (int i = 0; i < NumNarrowBanks; i++) e.nq[i] = narrow_op(5, 1'b0, '0, '0);
        for (int j = 0; j < NumWideBanks; j++) e.wq[j] = wide_op(10, 1'b0, '0, '0);
        stim_q.push_back(e);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        void'($urandom(65));
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        narrow_req = '0;
        wide_req   = '0;
        nf_mirror  = 1'b1;
        exp_nv     = '0;
        exp_wv     = '0;
        errors     = 0;
        n_tests    = 0;
        n_failed   = 0;
        for (int b = 0; b < NumNarrowBanks; b++) begin
            for (int a = 0; a < BankWords; a++) begin
                ref_mem[b][a] = 'x;
            end
        end
        build_table();
        repeat (3) @(negedge clk_i);
        cur.name    = "reset";
        test_errors = 0;
        check_responses();
        errors += test_errors;
        rst_ni = 1'b1;
        foreach (stim_q[k]) begin
            run_entry(stim_q[k]);
        end
        $display("tests=%0d failed=%0d errors=%0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
source/mem_cluster_pkg.sv
source/wide_narrow_arbiter.sv
source/bank_port_mux.sv
source/mem_bank.sv
source/mem_cluster_top.sv
tests/tb_mem_cluster.sv
